/* sched_pkg.sv */
//////////////////////////////
// Egress scheduler types
//////////////////////////////

`default_nettype none

package sched_pkg;

    //////////////////////////////
    // Sizes and constants
    localparam int NUM_PORTS       = 4;
    localparam int QUEUES_PER_PORT = 4;
    localparam int NUM_QUEUES      = 16;
    localparam int WORD_BYTES      = 64;
    localparam int ETH_OVERHEAD    = 20;
    localparam int CREDIT_MAX      = 65535;
    localparam int CFG_ADDR_ENABLE = 0;
    localparam int CFG_ADDR_RATE   = 1;
    // Drain rate after reset, bytes per cycle
    localparam int RATE_RESET      = 8;

    //////////////////////////////
    // Vector types
    typedef logic [$clog2(NUM_PORTS)-1:0]       port_t;
    typedef logic [$clog2(QUEUES_PER_PORT)-1:0] prio_t;
    // Port in the upper bits, priority in the lower bits
    typedef logic [$clog2(NUM_QUEUES)-1:0]      queue_id_t;
    typedef logic [NUM_PORTS-1:0]               port_mask_t;
    typedef logic [NUM_QUEUES-1:0]              queue_mask_t;
    typedef logic [$clog2(WORD_BYTES+1)-1:0]    byte_cnt_t;
    typedef logic [15:0]                        credit_t;
    typedef logic [7:0]                         rate_t;
    typedef logic [0:0]                         cfg_addr_t;
    typedef logic [7:0]                         cfg_data_t;

    //////////////////////////////
    // Bus structs
    typedef struct packed {
        logic      valid;
        queue_id_t queue;
    } dq_req_t;

    typedef struct packed {
        logic      valid;
        queue_id_t queue;
        byte_cnt_t bytes;
        logic      last;
    } dq_note_t;

    typedef struct packed {
        logic      valid;
        cfg_addr_t addr;
        cfg_data_t data;
    } cfg_wr_t;

    // Split and build a global queue number
    function automatic port_t queue_port(input queue_id_t q);
        return q[$bits(queue_id_t)-1 -: $bits(port_t)];
    endfunction

    function automatic prio_t queue_prio(input queue_id_t q);
        return q[$bits(prio_t)-1:0];
    endfunction

    function automatic queue_id_t make_queue(input port_t p, input prio_t pr);
        return {p, pr};
    endfunction

endpackage

`default_nettype wire

/* sched_config.sv */
//////////////////////////////
// Scheduler register block
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module sched_config (
    input  logic                   core_clk_ifc,
    input  logic                   rst_n,
    input  sched_pkg::cfg_wr_t     cfg_wr,
    output sched_pkg::port_mask_t  port_enable,
    output sched_pkg::rate_t       drain_rate
);

    import sched_pkg::*;

    logic wr_enable;
    logic wr_rate;

    // Address decode, one strobe per register
    always_comb begin
        wr_enable = cfg_wr.valid && (cfg_wr.addr == cfg_addr_t'(CFG_ADDR_ENABLE));
        wr_rate   = cfg_wr.valid && (cfg_wr.addr == cfg_addr_t'(CFG_ADDR_RATE));
    end

    //////////////////////////////
    // Registers

    // Only the low bits map to ports
    always_ff @(posedge core_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            port_enable <= '1;
        end else if (wr_enable) begin
            port_enable <= cfg_wr.data[NUM_PORTS-1:0];
        end
    end

    always_ff @(posedge core_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            drain_rate <= rate_t'(RATE_RESET);
        end else if (wr_rate) begin
            drain_rate <= rate_t'(cfg_wr.data);
        end
    end

endmodule

`default_nettype wire

/* port_shaper.sv */
//////////////////////////////
// Per-port byte shaper
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module port_shaper (
    input  logic                   core_clk_ifc,
    input  logic                   rst_n,
    input  sched_pkg::dq_note_t    dq_note,
    input  sched_pkg::rate_t       drain_rate,
    output sched_pkg::port_mask_t  shaper_ok
);

    import sched_pkg::*;

    // Two spare bits so charge plus credit cannot wrap
    typedef logic [$bits(credit_t)+1:0] credit_wide_t;

    credit_t      credit      [NUM_PORTS];
    credit_t      credit_next [NUM_PORTS];
    credit_wide_t charge      [NUM_PORTS];
    credit_wide_t credit_sum  [NUM_PORTS];
    port_t        note_port;

    assign note_port = queue_port(dq_note.queue);

    //////////////////////////////
    // Charge and drain

    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            charge[p] = '0;
            if (dq_note.valid && (note_port == port_t'(p))) begin
                charge[p] = credit_wide_t'(dq_note.bytes);
                // Interframe gap and preamble at packet end
                if (dq_note.last) begin
                    charge[p] = charge[p] + credit_wide_t'(ETH_OVERHEAD);
                end
            end
            credit_sum[p] = credit_wide_t'(credit[p]) + charge[p];

            if (credit_sum[p] <= credit_wide_t'(drain_rate)) begin
                credit_next[p] = '0;
            end else if (credit_sum[p] - credit_wide_t'(drain_rate)
                         > credit_wide_t'(CREDIT_MAX)) begin
                credit_next[p] = credit_t'(CREDIT_MAX);
            end else begin
                credit_next[p] = credit_t'(credit_sum[p] - credit_wide_t'(drain_rate));
            end
        end
    end

    always_ff @(posedge core_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                credit[p] <= '0;
            end
        end else begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                credit[p] <= credit_next[p];
            end
        end
    end

    // Port may send once its credit has fully drained
    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            shaper_ok[p] = (credit[p] == '0);
        end
    end

endmodule

`default_nettype wire

/* queue_select.sv */
//////////////////////////////
// Strict-priority queue pick
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module queue_select (
    input  logic                   core_clk_ifc,
    input  logic                   rst_n,
    input  sched_pkg::queue_mask_t queue_empty,
    input  sched_pkg::dq_req_t     dq_req,
    input  sched_pkg::dq_note_t    dq_note,
    output sched_pkg::prio_t       port_queue [sched_pkg::NUM_PORTS],
    output sched_pkg::port_mask_t  has_work
);

    import sched_pkg::*;

    port_mask_t lock;
    prio_t      lock_prio [NUM_PORTS];
    prio_t      best_prio [NUM_PORTS];
    port_mask_t any_ready;
    port_t      req_port;
    port_t      note_port;

    assign req_port  = queue_port(dq_req.queue);
    assign note_port = queue_port(dq_note.queue);

    //////////////////////////////
    // Highest non-empty queue

    // Ascending scan so the highest number wins
    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            best_prio[p] = '0;
            any_ready[p] = 1'b0;
            for (int q = 0; q < QUEUES_PER_PORT; q++) begin
                if (!queue_empty[p*QUEUES_PER_PORT + q]) begin
                    best_prio[p] = prio_t'(q);
                    any_ready[p] = 1'b1;
                end
            end
        end
    end

    // A packet in progress keeps its queue
    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (lock[p]) begin
                port_queue[p] = lock_prio[p];
                has_work[p]   = 1'b1;
            end else begin
                port_queue[p] = best_prio[p];
                has_work[p]   = any_ready[p];
            end
        end
    end

    //////////////////////////////
    // Packet locks

    always_ff @(posedge core_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            lock <= '0;
        end else begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (dq_note.valid && dq_note.last && (note_port == port_t'(p))) begin
                    lock[p] <= 1'b0;
                end else if (dq_req.valid && (req_port == port_t'(p)) && !lock[p]) begin
                    lock[p] <= 1'b1;
                end
            end
        end
    end

    // Captured on the first request of a packet
    always_ff @(posedge core_clk_ifc) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (dq_req.valid && (req_port == port_t'(p)) && !lock[p]) begin
                lock_prio[p] <= queue_prio(dq_req.queue);
            end
        end
    end

endmodule

`default_nettype wire

/* port_arbiter.sv */
//////////////////////////////
// Round-robin port arbiter
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module port_arbiter (
    input  logic                   core_clk_ifc,
    input  logic                   rst_n,
    input  sched_pkg::port_mask_t  port_enable,
    input  sched_pkg::port_mask_t  egr_ready,
    input  sched_pkg::port_mask_t  shaper_ok,
    input  sched_pkg::port_mask_t  has_work,
    input  sched_pkg::prio_t       port_queue [sched_pkg::NUM_PORTS],
    input  sched_pkg::dq_note_t    dq_note,
    output sched_pkg::dq_req_t     dq_req
);

    import sched_pkg::*;

    port_mask_t outstanding;
    port_mask_t eligible;
    port_t      last_grant;
    port_t      pick;
    logic       pick_valid;
    port_t      note_port;

    assign note_port = queue_port(dq_note.queue);
    assign eligible  = port_enable & egr_ready & shaper_ok & has_work & ~outstanding;

    // First eligible port after the last grant, wrapping
    always_comb begin
        port_t cand;
        pick       = '0;
        pick_valid = 1'b0;
        for (int i = 1; i <= NUM_PORTS; i++) begin
            cand = last_grant + port_t'(i);
            if (!pick_valid && eligible[cand]) begin
                pick       = cand;
                pick_valid = 1'b1;
            end
        end
    end

    //////////////////////////////
    // Request register

    always_ff @(posedge core_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            dq_req     <= '0;
            last_grant <= port_t'(NUM_PORTS - 1);
        end else begin
            dq_req.valid <= pick_valid;
            dq_req.queue <= make_queue(pick, port_queue[pick]);
            if (pick_valid) begin
                last_grant <= pick;
            end
        end
    end

    // One request in flight per port until its note returns
    always_ff @(posedge core_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            outstanding <= '0;
        end else begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (pick_valid && (pick == port_t'(p))) begin
                    outstanding[p] <= 1'b1;
                end else if (dq_note.valid && (note_port == port_t'(p))) begin
                    outstanding[p] <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* sched_top.sv */
//////////////////////////////
// Egress scheduler top
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module sched_top (
    input  logic                   core_clk_ifc,
    input  logic                   rst_n,
    input  sched_pkg::cfg_wr_t     cfg_wr,
    input  sched_pkg::queue_mask_t queue_empty,
    input  sched_pkg::port_mask_t  egr_ready,
    input  sched_pkg::dq_note_t    dq_note,
    output sched_pkg::dq_req_t     dq_req
);

    import sched_pkg::*;

    port_mask_t port_enable;
    rate_t      drain_rate;
    port_mask_t shaper_ok;
    port_mask_t has_work;
    prio_t      port_queue [NUM_PORTS];

    sched_config u_config (
        .core_clk_ifc (core_clk_ifc),
        .rst_n        (rst_n),
        .cfg_wr       (cfg_wr),
        .port_enable  (port_enable),
        .drain_rate   (drain_rate)
    );

    port_shaper u_shaper (
        .core_clk_ifc (core_clk_ifc),
        .rst_n        (rst_n),
        .dq_note      (dq_note),
        .drain_rate   (drain_rate),
        .shaper_ok    (shaper_ok)
    );

    queue_select u_queue_select (
        .core_clk_ifc (core_clk_ifc),
        .rst_n        (rst_n),
        .queue_empty  (queue_empty),
        .dq_req       (dq_req),
        .dq_note      (dq_note),
        .port_queue   (port_queue),
        .has_work     (has_work)
    );

    port_arbiter u_arbiter (
        .core_clk_ifc (core_clk_ifc),
        .rst_n        (rst_n),
        .port_enable  (port_enable),
        .egr_ready    (egr_ready),
        .shaper_ok    (shaper_ok),
        .has_work     (has_work),
        .port_queue   (port_queue),
        .dq_note      (dq_note),
        .dq_req       (dq_req)
    );

endmodule

`default_nettype wire

/* tb_sched.sv */
//////////////////////////////
// Scheduler testbench
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_sched;

    import sched_pkg::*;

    localparam int NUM_PKTS       = 40;
    localparam int TIMEOUT_CYCLES = 200000;
    localparam int CFG_STOP_CYCLE = 4000;

    logic        core_clk_ifc;
    logic        rst_n;
    cfg_wr_t     cfg_wr;
    queue_mask_t queue_empty;
    port_mask_t  egr_ready;
    dq_note_t    dq_note;
    dq_req_t     dq_req;

    // Queue store and responder
    int        pkts        [NUM_QUEUES][$];
    int        head_rem    [NUM_QUEUES];
    int        enq_bytes   [NUM_QUEUES];
    int        noted_bytes [NUM_QUEUES];
    logic      resp_valid;
    queue_id_t resp_queue;

    // Reference model state for the current cycle
    port_mask_t  en_m;
    int          rate_m;
    int          credit_m [NUM_PORTS];
    port_mask_t  out_m;
    port_mask_t  lock_m;
    prio_t       lockq_m  [NUM_PORTS];
    port_t       lg_m;
    logic        exp_valid;
    queue_id_t   exp_queue;
    int          cyc;
    logic [31:0] lfsr;

    sched_top UUT (
        .core_clk_ifc (core_clk_ifc),
        .rst_n        (rst_n),
        .cfg_wr       (cfg_wr),
        .queue_empty  (queue_empty),
        .egr_ready    (egr_ready),
        .dq_note      (dq_note),
        .dq_req       (dq_req)
    );

    always #5 core_clk_ifc = ~core_clk_ifc;

    //////////////////////////////
    // Random bits and checks

    function automatic int rand_bits(input int n);
        int r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            r = (r << 1) | int'(lfsr[0]);
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return r;
    endfunction

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic queue_check(input string name, input queue_id_t got, input queue_id_t exp);
        if (got !== exp)
            report_error($sformatf("error %s got 0x%0h expected 0x%0h", name, got, exp));
    endtask

    task automatic bytes_check(input string name, input byte_cnt_t got, input byte_cnt_t exp);
        if (got !== exp)
            report_error($sformatf("error %s got 0x%0h expected 0x%0h", name, got, exp));
    endtask

    task automatic credit_check(input string name, input credit_t got, input credit_t exp);
        if (got !== exp)
            report_error($sformatf("error %s got 0x%0h expected 0x%0h", name, got, exp));
    endtask

    task automatic total_check(input string name, input int got, input int exp);
        if (got != exp)
            report_error($sformatf("error %s got 0x%0h expected 0x%0h", name, got, exp));
    endtask

    //////////////////////////////
    // Model, responder, stimulus

    always @(posedge core_clk_ifc) begin : model_step
        port_mask_t elig;
        prio_t      offq [NUM_PORTS];
        port_t      pick;
        port_t      cand;
        logic       pick_valid;
        int         sum;
        int         piece;
        int         len;
        int         qi;
        dq_note_t   n;
        cfg_wr_t    w;
        if (rst_n) begin
            cyc++;
            // Request of this cycle against the prediction
            if (dq_req.valid !== exp_valid)
                report_error($sformatf("error dq_req.valid got 0x%0h expected 0x%0h",
                                       dq_req.valid, exp_valid));
            if (exp_valid)
                queue_check("dq_req.queue", dq_req.queue, exp_queue);
            if (dq_req.valid && queue_empty[dq_req.queue])
                report_error("request names an empty queue");
            for (int p = 0; p < NUM_PORTS; p++)
                credit_check($sformatf("credit[%0d]", p), UUT.u_shaper.credit[p],
                             credit_t'(credit_m[p]));

            // Offered queue and eligibility in this cycle
            elig = en_m & egr_ready & ~out_m;
            for (int p = 0; p < NUM_PORTS; p++) begin
                offq[p] = lockq_m[p];
                if (!lock_m[p]) begin
                    elig[p] = elig[p] & ~(&queue_empty[p*QUEUES_PER_PORT +: QUEUES_PER_PORT]);
                    for (int q = 0; q < QUEUES_PER_PORT; q++)
                        if (!queue_empty[p*QUEUES_PER_PORT + q])
                            offq[p] = prio_t'(q);
                end
                if (credit_m[p] != 0)
                    elig[p] = 1'b0;
            end
            pick_valid = 1'b0;
            pick       = '0;
            for (int i = 1; i <= NUM_PORTS; i++) begin
                cand = port_t'((int'(lg_m) + i) % NUM_PORTS);
                if (!pick_valid && elig[cand]) begin
                    pick       = cand;
                    pick_valid = 1'b1;
                end
            end

            // State for the next cycle
            for (int p = 0; p < NUM_PORTS; p++) begin
                sum = credit_m[p] - rate_m;
                if (dq_note.valid && dq_note.queue[3:2] == port_t'(p))
                    sum += int'(dq_note.bytes) + (dq_note.last ? ETH_OVERHEAD : 0);
                credit_m[p] = (sum < 0) ? 0 : ((sum > CREDIT_MAX) ? CREDIT_MAX : sum);
                if (pick_valid && pick == port_t'(p))
                    out_m[p] = 1'b1;
                else if (dq_note.valid && dq_note.queue[3:2] == port_t'(p))
                    out_m[p] = 1'b0;
                if (dq_note.valid && dq_note.last && dq_note.queue[3:2] == port_t'(p)) begin
                    lock_m[p] = 1'b0;
                end else if (exp_valid && exp_queue[3:2] == port_t'(p) && !lock_m[p]) begin
                    lock_m[p]  = 1'b1;
                    lockq_m[p] = exp_queue[1:0];
                end
            end
            if (pick_valid)
                lg_m = pick;
            exp_valid = pick_valid;
            exp_queue = {pick, offq[pick]};
            if (cfg_wr.valid && cfg_wr.addr == cfg_addr_t'(CFG_ADDR_ENABLE))
                en_m = cfg_wr.data[NUM_PORTS-1:0];
            else if (cfg_wr.valid)
                rate_m = int'(cfg_wr.data);

            // Note two cycles after the request
            n = '0;
            if (resp_valid) begin
                qi = int'(resp_queue);
                if (pkts[qi].size() == 0)
                    report_error("note due for a queue with no packet");
                if (head_rem[qi] == 0)
                    head_rem[qi] = pkts[qi][0];
                piece = (head_rem[qi] < WORD_BYTES) ? head_rem[qi] : WORD_BYTES;
                head_rem[qi]    -= piece;
                noted_bytes[qi] += piece;
                n.valid = 1'b1;
                n.queue = resp_queue;
                n.bytes = byte_cnt_t'(piece);
                n.last  = (head_rem[qi] == 0);
                if (n.last) begin
                    len = pkts[qi].pop_front();
                    bytes_check("dq_note.bytes", n.bytes,
                                byte_cnt_t'((len - 1) % WORD_BYTES + 1));
                    queue_empty[qi] <= (pkts[qi].size() == 0);
                end
            end
            dq_note    <= n;
            resp_valid = dq_req.valid;
            resp_queue = dq_req.queue;

            // Back-pressure and register writes
            for (int p = 0; p < NUM_PORTS; p++)
                egr_ready[p] <= (rand_bits(2) != 0);
            w = '0;
            if (cyc < CFG_STOP_CYCLE && rand_bits(5) == 0) begin
                w.valid = 1'b1;
                w.addr  = cfg_addr_t'(rand_bits(1));
                if (w.addr == cfg_addr_t'(CFG_ADDR_ENABLE))
                    w.data = cfg_data_t'(rand_bits(NUM_PORTS));
                else
                    w.data = cfg_data_t'(2 + rand_bits(5));
            end else if (cyc == CFG_STOP_CYCLE) begin
                // All ports back on for the drain
                w.valid = 1'b1;
                w.addr  = cfg_addr_t'(CFG_ADDR_ENABLE);
                w.data  = 8'hff;
            end
            cfg_wr <= w;
        end
    end

    //////////////////////////////
    // Main sequence

    initial begin : main_seq
        int          q;
        int          len;
        int          wait_cyc;
        queue_mask_t mask;
        lfsr         = 32'd85447;
        core_clk_ifc = 1'b0;
        rst_n        <= 1'b0;
        cfg_wr       <= '0;
        egr_ready    <= '1;
        dq_note      <= '0;
        en_m       = '1;
        rate_m     = RATE_RESET;
        out_m      = '0;
        lock_m     = '0;
        lg_m       = port_t'(NUM_PORTS - 1);
        exp_valid  = 1'b0;
        exp_queue  = '0;
        resp_valid = 1'b0;
        resp_queue = '0;
        cyc        = 0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            credit_m[p] = 0;
            lockq_m[p]  = '0;
        end
        for (int i = 0; i < NUM_QUEUES; i++) begin
            head_rem[i]    = 0;
            enq_bytes[i]   = 0;
            noted_bytes[i] = 0;
        end
        // Whole packet load before reset release
        mask = '1;
        for (int k = 0; k < NUM_PKTS; k++) begin
            q   = rand_bits(4);
            len = 64 + rand_bits(11) % 1437;
            pkts[q].push_back(len);
            enq_bytes[q] += len;
            mask[q] = 1'b0;
        end
        queue_empty <= mask;
        repeat (5) @(posedge core_clk_ifc);
        rst_n <= 1'b1;

        wait_cyc = 0;
        while (!(&queue_empty) || resp_valid || dq_note.valid || exp_valid || out_m != '0) begin
            @(negedge core_clk_ifc);
            wait_cyc++;
            if (wait_cyc > TIMEOUT_CYCLES)
                report_error("timeout while waiting for all queues to drain");
        end
        for (int i = 0; i < NUM_QUEUES; i++)
            total_check($sformatf("noted bytes of queue %0d", i), noted_bytes[i], enq_bytes[i]);
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
sched_pkg.sv
sched_config.sv
port_shaper.sv
queue_select.sv
port_arbiter.sv
sched_top.sv
tb_sched.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the scheduler testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing -j 0 --top-module tb_sched -f flist.f -o sim_tb_sched &&
./obj_dir/sim_tb_sched ||
{ echo "Simulation did not complete successfully"; exit 1; }
